//--- cpuPkg.sv
package cpuPkg;

	// Unified memory geometry, word addressed
	localparam int memAddrWidth = 10;
	localparam int memDepth = 1024;

	// Multiplier occupancy after a mult
	localparam int mdLatency = 5;
	localparam int mdCntWidth = $clog2(mdLatency + 1);

	// Primary opcodes
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;

	// Function codes under opRtype
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnMult = 6'h18;
	localparam logic [5:0] fnMfhi = 6'h10;
	localparam logic [5:0] fnMflo = 6'h12;

	// When a producer's result exists
	typedef enum logic [1:0] {tNone, tAlu, tDm} tnewT;

	typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic mdStart;
		logic mdRead;
		logic mdSelHi;
		logic [4:0] dest;
	} ctrlT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		ctrlT ctrl;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
	} exStageT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		ctrlT ctrl;
		logic [31:0] aluResult;
		logic [31:0] storeData;
	} memStageT;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		ctrlT ctrl;
		logic [31:0] result;
	} wbStageT;

endpackage

//--- memBus.sv
`timescale 1ns/100ps

// One requester's path into the shared memory
interface memBus import cpuPkg::*; ();

	logic req;
	logic we;
	logic [memAddrWidth-1:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic gnt;

	modport requester (
		output req, we, addr, wdata,
		input rdata, gnt
	);

	modport arbiter (
		input req, we, addr, wdata,
		output rdata, gnt
	);

endinterface

//--- memArbiter.sv
`timescale 1ns/100ps

module memArbiter import cpuPkg::*; (
	memBus.arbiter loadBus,
	memBus.arbiter dataBus,
	memBus.arbiter fetchBus,
	output logic memWe,
	output logic [memAddrWidth-1:0] memAddr,
	output logic [31:0] memWdata,
	input logic [31:0] memRdata
);

	// Fixed priority: load port, then data, then fetch
	assign loadBus.gnt = loadBus.req;
	assign dataBus.gnt = dataBus.req && !loadBus.req;
	assign fetchBus.gnt = fetchBus.req && !loadBus.req && !dataBus.req;

	always_comb begin
		memWe = 1'b0;
		memAddr = fetchBus.addr;
		memWdata = fetchBus.wdata;
		if (loadBus.gnt) begin
			memWe = loadBus.we;
			memAddr = loadBus.addr;
			memWdata = loadBus.wdata;
		end else if (dataBus.gnt) begin
			memWe = dataBus.we;
			memAddr = dataBus.addr;
			memWdata = dataBus.wdata;
		end
	end

	// Read data goes back to everyone, only the granted one uses it
	assign loadBus.rdata = memRdata;
	assign dataBus.rdata = memRdata;
	assign fetchBus.rdata = memRdata;

endmodule

//--- unifiedMem.sv
`timescale 1ns/100ps

module unifiedMem import cpuPkg::*; (
	input logic clk,
	input logic we,
	input logic [memAddrWidth-1:0] addr,
	input logic [31:0] wdata,
	output logic [31:0] rdata
);

	logic [31:0] mem [memDepth];

	// Combinational read port
	assign rdata = mem[addr];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

//--- instrDecode.sv
`timescale 1ns/100ps

module instrDecode import cpuPkg::*; (
	input logic [31:0] instr,
	output ctrlT ctrl,
	output logic useRs0,
	output logic useRs1,
	output logic useRt0,
	output logic useRt1,
	output logic isMd,
	output tnewT tnew
);

	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rt;
	logic [4:0] rd;

	assign op = instr[31:26];
	assign fn = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb begin
		ctrl = '0;
		useRs0 = 1'b0;
		useRs1 = 1'b0;
		useRt0 = 1'b0;
		useRt1 = 1'b0;
		isMd = 1'b0;
		tnew = tNone;
		case (op)
			opRtype: begin
				case (fn)
					fnAddu, fnSubu: begin
						if (fn == fnSubu) begin
							ctrl.aluOp = aluSub;
						end
						ctrl.regWrite = 1'b1;
						ctrl.dest = rd;
						useRs1 = 1'b1;
						useRt1 = 1'b1;
						tnew = tAlu;
					end
					fnMult: begin
						ctrl.mdStart = 1'b1;
						useRs1 = 1'b1;
						useRt1 = 1'b1;
						isMd = 1'b1;
					end
					fnMfhi, fnMflo: begin
						ctrl.mdRead = 1'b1;
						ctrl.mdSelHi = (fn == fnMfhi);
						ctrl.regWrite = 1'b1;
						ctrl.dest = rd;
						isMd = 1'b1;
						tnew = tAlu;
					end
					default: ;
				endcase
			end
			opOri, opLui: begin
				ctrl.aluOp = (op == opOri) ? aluOr : aluLui;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rt;
				useRs1 = (op == opOri);
				tnew = tAlu;
			end
			opLw: begin
				ctrl.useImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.dest = rt;
				useRs1 = 1'b1;
				tnew = tDm;
			end
			opSw: begin
				// Store data is only needed in execute
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
				useRs1 = 1'b1;
				useRt1 = 1'b1;
			end
			opBeq: begin
				ctrl.isBranch = 1'b1;
				useRs0 = 1'b1;
				useRt0 = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- stallControl.sv
`timescale 1ns/100ps

module stallControl import cpuPkg::*; (
	input logic [31:0] instrD,
	input logic [31:0] instrE,
	input logic [31:0] instrM,
	input logic [4:0] destE,
	input logic [4:0] destM,
	input logic mdBusy,
	output logic enPC,
	output logic enD,
	output logic clrE
);

	logic useRs0, useRs1, useRt0, useRt1, isMdD;
	ctrlT ctrlE;
	tnewT tnewE, tnewM;
	logic rsHitE, rsHitM, rtHitE, rtHitM;
	logic stallRs, stallRt, stallMd, stall;

	instrDecode decD (
		.instr(instrD),
		.ctrl(),
		.useRs0(useRs0),
		.useRs1(useRs1),
		.useRt0(useRt0),
		.useRt1(useRt1),
		.isMd(isMdD),
		.tnew()
	);

	instrDecode decE (
		.instr(instrE),
		.ctrl(ctrlE),
		.useRs0(), .useRs1(), .useRt0(), .useRt1(), .isMd(),
		.tnew(tnewE)
	);

	instrDecode decM (
		.instr(instrM),
		.ctrl(),
		.useRs0(), .useRs1(), .useRt0(), .useRt1(), .isMd(),
		.tnew(tnewM)
	);

	// Register matches against a real destination
	assign rsHitE = (instrD[25:21] == destE) && (destE != 5'd0);
	assign rsHitM = (instrD[25:21] == destM) && (destM != 5'd0);
	assign rtHitE = (instrD[20:16] == destE) && (destE != 5'd0);
	assign rtHitM = (instrD[20:16] == destM) && (destM != 5'd0);

	////////////////////////////////////////////////////////////
	// Use time against new-value time
	////////////////////////////////////////////////////////////
	always_comb begin
		stallRs = (useRs0 && rsHitE && tnewE != tNone)
			|| (useRs0 && rsHitM && tnewM == tDm)
			|| (useRs1 && rsHitE && tnewE == tDm);
		stallRt = (useRt0 && rtHitE && tnewE != tNone)
			|| (useRt0 && rtHitM && tnewM == tDm)
			|| (useRt1 && rtHitE && tnewE == tDm);
		// hi/lo not settled while a mult is in flight
		stallMd = isMdD && (mdBusy || ctrlE.mdStart);
		stall = stallRs || stallRt || stallMd;
	end

	assign enPC = !stall;
	assign enD = !stall;
	assign clrE = stall;

endmodule

//--- mdUnit.sv
`timescale 1ns/100ps

module mdUnit import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic start,
	input logic read,
	input logic selHi,
	input logic [31:0] opA,
	input logic [31:0] opB,
	output logic [31:0] result,
	output logic busy
);

	logic [mdCntWidth-1:0] count;
	logic [63:0] product;
	logic [31:0] hi, lo;

	// Unsigned product captured when the mult is in execute
	always_ff @(posedge clk) begin
		if (start) begin
			product <= {32'b0, opA} * {32'b0, opB};
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
			hi <= '0;
			lo <= '0;
		end else if (start) begin
			count <= mdCntWidth'(mdLatency);
		end else if (count != '0) begin
			count <= count - 1'b1;
			// Last busy cycle, hi/lo visible as busy drops
			if (count == mdCntWidth'(1)) begin
				{hi, lo} <= product;
			end
		end
	end

	assign busy = (count != '0);
	assign result = read ? (selHi ? hi : lo) : 32'd0;

endmodule

//--- mipsCore.sv
`timescale 1ns/100ps

module mipsCore import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	memBus.requester fetchBus,
	memBus.requester dataBus,
	output logic mdStart,
	output logic mdRead,
	output logic mdSelHi,
	output logic [31:0] mdOpA,
	output logic [31:0] mdOpB,
	input logic [31:0] mdResult,
	input logic mdBusy,
	output logic wbEn,
	output logic [4:0] wbReg,
	output logic [31:0] wbData,
	output logic [31:0] wbPc
);

	logic [31:0] pc, pcD, instrD;
	logic pendValid;
	logic [31:0] pendTarget;
	exStageT stageE;
	memStageT stageM;
	wbStageT stageW;
	logic [31:0] regs [32];
	ctrlT ctrlD;
	logic enPC, enD, clrE;
	logic [31:0] rsD, rtD, rsE, rtE, immE, opB, aluOut, resultE;
	logic [31:0] branchTarget;
	logic takenD;

	// Newest of memory and writeback or else the given value
	function automatic logic [31:0] forward(input logic [4:0] src, input logic [31:0] dflt);
		if (src == 5'd0)
			return 32'd0;
		if (stageM.ctrl.regWrite && !stageM.ctrl.memRead && stageM.ctrl.dest == src)
			return stageM.aluResult;
		if (stageW.ctrl.regWrite && stageW.ctrl.dest == src)
			return stageW.result;
		return dflt;
	endfunction

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////
	assign fetchBus.req = enPC;
	assign fetchBus.we = 1'b0;
	assign fetchBus.addr = pc[memAddrWidth+1:2];
	assign fetchBus.wdata = 32'd0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			pendValid <= 1'b0;
			pendTarget <= '0;
		end else begin
			// Taken branch whose delay slot lost the bus
			if (takenD && !fetchBus.gnt) begin
				pendValid <= 1'b1;
				pendTarget <= branchTarget;
			end else if (fetchBus.gnt) begin
				pendValid <= 1'b0;
			end
			if (fetchBus.gnt) begin
				pc <= pendValid ? pendTarget : (takenD ? branchTarget : pc + 32'd4);
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrD <= '0;
			pcD <= '0;
		end else if (enD) begin
			instrD <= fetchBus.gnt ? fetchBus.rdata : 32'd0;
			pcD <= pc;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	instrDecode decD (
		.instr(instrD),
		.ctrl(ctrlD),
		.useRs0(), .useRs1(), .useRt0(), .useRt1(), .isMd(), .tnew()
	);

	stallControl hazard (
		.instrD(instrD),
		.instrE(stageE.instr),
		.instrM(stageM.instr),
		.destE(stageE.ctrl.dest),
		.destM(stageM.ctrl.dest),
		.mdBusy(mdBusy),
		.enPC(enPC),
		.enD(enD),
		.clrE(clrE)
	);

	always_comb begin
		rsD = forward(instrD[25:21], regs[instrD[25:21]]);
		rtD = forward(instrD[20:16], regs[instrD[20:16]]);
		takenD = ctrlD.isBranch && (rsD == rtD) && enD;
		branchTarget = pcD + 32'd4 + {{14{instrD[15]}}, instrD[15:0], 2'b00};
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stageE <= '0;
		end else if (clrE) begin
			stageE <= '0;
		end else begin
			stageE.pc <= pcD;
			stageE.instr <= instrD;
			stageE.ctrl <= ctrlD;
			stageE.rsVal <= rsD;
			stageE.rtVal <= rtD;
		end
	end

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////
	always_comb begin
		rsE = forward(stageE.instr[25:21], stageE.rsVal);
		rtE = forward(stageE.instr[20:16], stageE.rtVal);
		// ori zero-extends while address offsets sign-extend
		if (stageE.instr[31:26] == opOri)
			immE = {16'd0, stageE.instr[15:0]};
		else
			immE = {{16{stageE.instr[15]}}, stageE.instr[15:0]};
		opB = stageE.ctrl.useImm ? immE : rtE;
		case (stageE.ctrl.aluOp)
			aluSub: aluOut = rsE - opB;
			aluOr: aluOut = rsE | opB;
			aluLui: aluOut = {stageE.instr[15:0], 16'd0};
			default: aluOut = rsE + opB;
		endcase
		resultE = stageE.ctrl.mdRead ? mdResult : aluOut;
	end

	assign mdStart = stageE.ctrl.mdStart;
	assign mdRead = stageE.ctrl.mdRead;
	assign mdSelHi = stageE.ctrl.mdSelHi;
	assign mdOpA = rsE;
	assign mdOpB = rtE;

	////////////////////////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////////////////////////
	assign dataBus.req = stageM.ctrl.memRead || stageM.ctrl.memWrite;
	assign dataBus.we = stageM.ctrl.memWrite;
	assign dataBus.addr = stageM.aluResult[memAddrWidth+1:2];
	assign dataBus.wdata = stageM.storeData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stageM <= '0;
			stageW <= '0;
		end else begin
			stageM.pc <= stageE.pc;
			stageM.instr <= stageE.instr;
			stageM.ctrl <= stageE.ctrl;
			stageM.aluResult <= resultE;
			stageM.storeData <= rtE;
			stageW.pc <= stageM.pc;
			stageW.instr <= stageM.instr;
			stageW.ctrl <= stageM.ctrl;
			stageW.result <= stageM.ctrl.memRead ? dataBus.rdata : stageM.aluResult;
		end
	end

	// r0 stays zero
	always_ff @(posedge clk) begin
		if (stageW.ctrl.regWrite && stageW.ctrl.dest != 5'd0) begin
			regs[stageW.ctrl.dest] <= stageW.result;
		end
	end

	assign wbEn = stageW.ctrl.regWrite;
	assign wbReg = stageW.ctrl.dest;
	assign wbData = stageW.result;
	assign wbPc = stageW.pc;

endmodule

//--- cpuTop.sv
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input logic progWe,
	input logic [memAddrWidth-1:0] progAddr,
	input logic [31:0] progData,
	output logic wbEn,
	output logic [4:0] wbReg,
	output logic [31:0] wbData,
	output logic [31:0] wbPc
);

	logic mdStart, mdRead, mdSelHi, mdBusy;
	logic [31:0] mdOpA, mdOpB, mdResult;
	logic memWe;
	logic [memAddrWidth-1:0] memAddr;
	logic [31:0] memWdata, memRdata;

	memBus loadBus ();
	memBus dataBus ();
	memBus fetchBus ();

	// Program load port, write only
	assign loadBus.req = progWe;
	assign loadBus.we = progWe;
	assign loadBus.addr = progAddr;
	assign loadBus.wdata = progData;

	mipsCore core (
		.clk(clk), .rstN(rstN),
		.fetchBus(fetchBus.requester), .dataBus(dataBus.requester),
		.mdStart(mdStart), .mdRead(mdRead), .mdSelHi(mdSelHi),
		.mdOpA(mdOpA), .mdOpB(mdOpB), .mdResult(mdResult), .mdBusy(mdBusy),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc)
	);

	mdUnit md (
		.clk(clk), .rstN(rstN),
		.start(mdStart), .read(mdRead), .selHi(mdSelHi),
		.opA(mdOpA), .opB(mdOpB), .result(mdResult), .busy(mdBusy)
	);

	memArbiter arb (
		.loadBus(loadBus.arbiter), .dataBus(dataBus.arbiter), .fetchBus(fetchBus.arbiter),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata)
	);

	unifiedMem mem (
		.clk(clk), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
	);

endmodule

//--- cpuTb_checker.sv
`timescale 1ns/100ps

// Watches the stall controller outputs and the memory grants
module cpuTb_checker (
	input logic clk,
	input logic rstN,
	input logic enPC,
	input logic enD,
	input logic clrE,
	input logic loadGnt,
	input logic dataGnt,
	input logic fetchGnt,
	input logic dataReq
);

	int assertFails = 0;

	// Single-port memory serves one requester per cycle
	grantOneHot: assert property (@(posedge clk) $onehot0({loadGnt, dataGnt, fetchGnt}))
		else begin
			$error("More than one memory grant in the same cycle");
			assertFails++;
		end

	stallConsistent: assert property (@(posedge clk) disable iff (!rstN)
		(enPC == !clrE) && (enD == !clrE))
		else begin
			$error("enPC or enD disagrees with clrE");
			assertFails++;
		end

	// Memory stage access wins over fetch
	dataBeatsFetch: assert property (@(posedge clk) disable iff (!rstN)
		!(dataReq && fetchGnt))
		else begin
			$error("Fetch granted while the data bus requests");
			assertFails++;
		end

endmodule

bind cpuTop cpuTb_checker checks (
	.clk(clk),
	.rstN(rstN),
	.enPC(core.enPC),
	.enD(core.enD),
	.clrE(core.clrE),
	.loadGnt(loadBus.gnt),
	.dataGnt(dataBus.gnt),
	.fetchGnt(fetchBus.gnt),
	.dataReq(dataBus.req)
);

//--- cpuTb.sv
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

	// Instruction words over all five programs including end loops
	localparam int totalInstr = 68;
	localparam int cycleLimit = 20 * totalInstr + 100;
	// beq r0, r0, -1 spins on itself with a nop delay slot
	localparam logic [31:0] loopWord = {opBeq, 5'd0, 5'd0, 16'hffff};

	logic clk;
	logic rstN;
	logic progWe;
	logic [memAddrWidth-1:0] progAddr;
	logic [31:0] progData;
	logic wbEn;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic [31:0] wbPc;

	int cycles = 0;
	int errors = 0;
	int checks = 0;
	logic [31:0] lfsrState = 32'hbe37c472;

	logic [31:0] prog [$];
	logic [memAddrWidth-1:0] dataAddr [$];
	logic [31:0] dataVal [$];
	logic [31:0] refMem [memDepth];
	logic [31:0] refRegs [32];
	logic [31:0] expPc [$];
	logic [4:0] expReg [$];
	logic [31:0] expData [$];
	logic [31:0] gotPc [$];
	logic [4:0] gotReg [$];
	logic [31:0] gotData [$];
	int gotCycle [$];

	cpuTop u_dut (
		.clk(clk), .rstN(rstN),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Run stopped after %0d cycles before the tests finished", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// Writeback strobes sampled mid-cycle
	always @(negedge clk) begin
		if (rstN && wbEn) begin
			gotPc.push_back(wbPc);
			gotReg.push_back(wbReg);
			gotData.push_back(wbData);
			gotCycle.push_back(cycles);
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////
	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] randomWord();
		logic [31:0] w;
		logic fb;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			w = {w[30:0], fb};
		end
		return w;
	endfunction

	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic newProgram();
		prog.delete();
		dataAddr.delete();
		dataVal.delete();
	endtask

	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		prog.push_back(encI(opLui, 5'd0, rd, value[31:16]));
		prog.push_back(encI(opOri, rd, rd, value[15:0]));
	endtask

	task automatic writeWord(input logic [memAddrWidth-1:0] addr, input logic [31:0] data);
		progWe = 1'b1;
		progAddr = addr;
		progData = data;
		refMem[addr] = data;
		@(posedge clk);
		#10;
	endtask

	task automatic expectWrite(input logic [31:0] pc, input logic [4:0] dest,
		input logic [31:0] value);
		expPc.push_back(pc);
		expReg.push_back(dest);
		expData.push_back(value);
		if (dest != 5'd0) begin
			refRegs[dest] = value;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Architectural model of the loaded program
	////////////////////////////////////////////////////////////
	task automatic runReference(input string name);
		logic [31:0] pc, nextPc, target, instr, a, b, imm, ea;
		logic [31:0] hi, lo;
		logic pending;
		int steps;
		pc = '0;
		pending = 1'b0;
		target = '0;
		hi = '0;
		lo = '0;
		steps = 0;
		for (int r = 0; r < 32; r++) begin
			refRegs[r] = '0;
		end
		instr = refMem[pc[memAddrWidth+1:2]];
		while (instr != loopWord && steps < 200) begin
			a = refRegs[instr[25:21]];
			b = refRegs[instr[20:16]];
			imm = {{16{instr[15]}}, instr[15:0]};
			ea = a + imm;
			// A taken branch redirects after its delay slot
			nextPc = pending ? target : pc + 32'd4;
			pending = 1'b0;
			case (instr[31:26])
				opRtype: begin
					case (instr[5:0])
						fnAddu: expectWrite(pc, instr[15:11], a + b);
						fnSubu: expectWrite(pc, instr[15:11], a - b);
						fnMult: {hi, lo} = {32'd0, a} * {32'd0, b};
						fnMfhi: expectWrite(pc, instr[15:11], hi);
						fnMflo: expectWrite(pc, instr[15:11], lo);
						default: ;
					endcase
				end
				opOri: expectWrite(pc, instr[20:16], a | {16'd0, instr[15:0]});
				opLui: expectWrite(pc, instr[20:16], {instr[15:0], 16'd0});
				opLw: expectWrite(pc, instr[20:16], refMem[ea[memAddrWidth+1:2]]);
				opSw: refMem[ea[memAddrWidth+1:2]] = b;
				opBeq: begin
					if (a == b) begin
						pending = 1'b1;
						target = pc + 32'd4 + (imm << 2);
					end
				end
				default: ;
			endcase
			pc = nextPc;
			steps++;
			instr = refMem[pc[memAddrWidth+1:2]];
		end
		if (steps >= 200) begin
			$display("Reference model of %s never reached the end loop", name);
			errors++;
		end
	endtask

	task automatic compareRecords(input string name, input bit backToBack);
		int n;
		checks++;
		if (gotPc.size() != expPc.size()) begin
			$display("FAILED at %0t: %s writeback count expected %0d, got %0d",
				$time, name, expPc.size(), gotPc.size());
			errors++;
		end
		n = (gotPc.size() < expPc.size()) ? gotPc.size() : expPc.size();
		for (int i = 0; i < n; i++) begin
			checks++;
			if (gotPc[i] !== expPc[i]) begin
				$display("FAILED at %0t: %s wbPc[%0d] expected %h, got %h",
					$time, name, i, expPc[i], gotPc[i]);
				errors++;
			end
			if (gotReg[i] !== expReg[i]) begin
				$display("FAILED at %0t: %s wbReg[%0d] expected %0d, got %0d",
					$time, name, i, expReg[i], gotReg[i]);
				errors++;
			end
			if (gotData[i] !== expData[i]) begin
				$display("FAILED at %0t: %s wbData[%0d] expected %h, got %h",
					$time, name, i, expData[i], gotData[i]);
				errors++;
			end
			if (backToBack && i > 0 && gotCycle[i] != gotCycle[i-1] + 1) begin
				$display("FAILED at %0t: %s wbEn gap before record %0d expected 1, got %0d",
					$time, name, i, gotCycle[i] - gotCycle[i-1]);
				errors++;
			end
		end
	endtask

	// Load under reset and run until every expected writeback is seen
	task automatic runProgram(input string name, input bit backToBack);
		prog.push_back(loopWord);
		prog.push_back(32'd0);
		@(posedge clk);
		#10;
		rstN = 1'b0;
		gotPc.delete();
		gotReg.delete();
		gotData.delete();
		gotCycle.delete();
		expPc.delete();
		expReg.delete();
		expData.delete();
		foreach (prog[i]) begin
			writeWord(memAddrWidth'(i), prog[i]);
		end
		foreach (dataAddr[i]) begin
			writeWord(dataAddr[i], dataVal[i]);
		end
		progWe = 1'b0;
		runReference(name);
		repeat (5) @(posedge clk);
		#10;
		rstN = 1'b1;
		while (gotPc.size() < expPc.size()) begin
			@(negedge clk);
		end
		// Window for any stray retirement
		repeat (8) @(negedge clk);
		compareRecords(name, backToBack);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic aluChainTest();
		logic [31:0] a, b;
		a = randomWord();
		b = randomWord();
		newProgram();
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		prog.push_back(encR(5'd1, 5'd2, 5'd3, fnAddu));
		prog.push_back(encR(5'd3, 5'd1, 5'd4, fnSubu));
		prog.push_back(encI(opOri, 5'd4, 5'd5, a[15:0] ^ b[31:16]));
		prog.push_back(encR(5'd5, 5'd3, 5'd6, fnAddu));
		prog.push_back(encI(opLui, 5'd0, 5'd7, b[15:0]));
		prog.push_back(encR(5'd7, 5'd6, 5'd8, fnSubu));
		prog.push_back(encI(opOri, 5'd8, 5'd9, 16'h0f0f));
		runProgram("ALU chain", 1'b1);
	endtask

	task automatic loadStoreTest();
		logic [31:0] a;
		a = randomWord();
		newProgram();
		dataAddr.push_back(10'h100);
		dataVal.push_back(randomWord());
		loadConst(5'd1, a);
		prog.push_back(encI(opLw, 5'd0, 5'd2, 16'h0400));
		prog.push_back(encR(5'd2, 5'd1, 5'd3, fnAddu));
		prog.push_back(encI(opSw, 5'd0, 5'd3, 16'h0404));
		prog.push_back(encI(opLw, 5'd0, 5'd4, 16'h0404));
		prog.push_back(encR(5'd4, 5'd2, 5'd5, fnAddu));
		prog.push_back(encI(opSw, 5'd0, 5'd5, 16'h0408));
		prog.push_back(encI(opLw, 5'd0, 5'd6, 16'h0408));
		prog.push_back(encR(5'd6, 5'd1, 5'd7, fnSubu));
		runProgram("load and store", 1'b0);
	endtask

	task automatic branchTest();
		newProgram();
		dataAddr.push_back(10'h103);
		dataVal.push_back(32'd3);
		prog.push_back(encI(opOri, 5'd0, 5'd1, 16'd5));
		prog.push_back(encI(opOri, 5'd0, 5'd2, 16'd5));
		prog.push_back(encI(opBeq, 5'd1, 5'd2, 16'd2));
		prog.push_back(encI(opOri, 5'd0, 5'd3, 16'd1));
		prog.push_back(encI(opOri, 5'd0, 5'd4, 16'd2));
		prog.push_back(encI(opOri, 5'd0, 5'd5, 16'd3));
		prog.push_back(encI(opBeq, 5'd1, 5'd3, 16'd1));
		prog.push_back(encI(opOri, 5'd0, 5'd6, 16'd4));
		prog.push_back(encI(opOri, 5'd0, 5'd7, 16'd6));
		// Branch on a register loaded just before it
		prog.push_back(encI(opLw, 5'd0, 5'd8, 16'h040c));
		prog.push_back(encI(opBeq, 5'd8, 5'd5, 16'd2));
		prog.push_back(encI(opOri, 5'd0, 5'd9, 16'd9));
		prog.push_back(encI(opOri, 5'd0, 5'd10, 16'd10));
		prog.push_back(encI(opOri, 5'd0, 5'd11, 16'd11));
		runProgram("branch", 1'b0);
	endtask

	task automatic multiplyTest();
		newProgram();
		loadConst(5'd1, randomWord());
		loadConst(5'd2, randomWord());
		prog.push_back(encR(5'd1, 5'd2, 5'd0, fnMult));
		prog.push_back(encR(5'd0, 5'd0, 5'd3, fnMfhi));
		prog.push_back(encR(5'd0, 5'd0, 5'd4, fnMflo));
		prog.push_back(encR(5'd3, 5'd4, 5'd5, fnAddu));
		prog.push_back(encR(5'd3, 5'd4, 5'd0, fnMult));
		prog.push_back(encR(5'd0, 5'd0, 5'd6, fnMflo));
		prog.push_back(encR(5'd0, 5'd0, 5'd7, fnMfhi));
		runProgram("multiply", 1'b0);
	endtask

	task automatic zeroRegTest();
		newProgram();
		prog.push_back(encI(opOri, 5'd0, 5'd0, 16'h0055));
		prog.push_back(encR(5'd0, 5'd0, 5'd1, fnAddu));
		loadConst(5'd2, randomWord());
		prog.push_back(encI(opSw, 5'd0, 5'd2, 16'h0410));
		prog.push_back(encI(opLw, 5'd0, 5'd0, 16'h0410));
		prog.push_back(encR(5'd0, 5'd2, 5'd3, fnAddu));
		prog.push_back(encI(opSw, 5'd0, 5'd3, 16'h0414));
		prog.push_back(encI(opLw, 5'd0, 5'd4, 16'h0414));
		prog.push_back(encI(opLw, 5'd0, 5'd5, 16'h0410));
		prog.push_back(encR(5'd4, 5'd5, 5'd6, fnAddu));
		prog.push_back(encI(opOri, 5'd0, 5'd7, 16'd7));
		runProgram("r0 and bus sharing", 1'b0);
	endtask

	initial begin
		rstN = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		aluChainTest();
		loadStoreTest();
		branchTest();
		multiplyTest();
		zeroRegTest();
		errors += u_dut.checks.assertFails;
		$display("Finished with %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- compile.f
cpuPkg.sv
memBus.sv
memArbiter.sv
unifiedMem.sv
instrDecode.sv
stallControl.sv
mdUnit.sv
mipsCore.sv
cpuTop.sv
cpuTb_checker.sv
cpuTb.sv

//--- Bender.yml
package:
  name: mips_pipe

sources:
  - cpuPkg.sv
  - memBus.sv
  - memArbiter.sv
  - unifiedMem.sv
  - instrDecode.sv
  - stallControl.sv
  - mdUnit.sv
  - mipsCore.sv
  - cpuTop.sv
  - target: simulation
    files:
      - cpuTb_checker.sv
      - cpuTb.sv
